// File: hdl/link_pkg.sv
// ******************************
// link packet definitions shared by the
// transmit and receive sides of the game link.
// ******************************

package link_pkg;

    // one frame on the wire is a start bit, eight data bits and a stop bit.
    localparam int FRAME_BITS = 10;

    // ******************************
    // packet fields
    // ******************************

    // what a packet means to the opponent.
    typedef enum logic [1:0] {
        PKT_NOP,      // filler, nobody reacts to it.
        PKT_ACK,      // ready handshake or loss acknowledge.
        PKT_GAME_END, // the sender has topped out.
        PKT_GARBAGE   // attack lines, count in the payload.
    } pkt_kind_t;

    typedef logic [5:0] garbage_t; // number of garbage lines in one attack.

    // position of the current bit inside a frame, 0 is the start bit.
    typedef logic [3:0] bit_idx_t;

    // the byte that goes on the wire.
    // kind sits in the top two bits, so it is sent last.
    typedef struct packed {
        pkt_kind_t kind;
        garbage_t  payload; // zero unless kind is PKT_GARBAGE.
    } link_pkt_t;

endpackage : link_pkg

// File: hdl/session_ctrl.sv
// ******************************
// session FSM for one player. it starts and ends a game
// together with the opponent and asks for ACK or
// GAME_END packets while it waits on the other side.
// ******************************
`timescale 1ns/100ps

module session_ctrl
    import link_pkg::*;
(
    input  logic      clk,
    input  logic      rst_l,
    input  logic      player_ready,   // player wants a two-player game.
    input  logic      player_unready, // player cancels before the start.
    input  logic      top_out,        // our stack overflowed, we lost.
    input  logic      ack_seen,       // opponent sent ACK.
    input  logic      game_end_seen,  // opponent lost, so we won.
    output logic      req,            // four-phase request to the arbiter.
    input  logic      ack,            // four-phase acknowledge from the arbiter.
    output link_pkt_t pkt,            // packet offered with req.
    output logic      game_active,
    output logic      in_game,
    output logic      game_lost
);

    typedef enum logic [1:0] {
        IDLE,
        GAME_READY,
        IN_GAME,
        GAME_LOST
    } session_state_t;

    session_state_t state, next_state;
    logic           want_send; // this state keeps asking for packets.
    logic           start_req; // begin a new handshake this cycle.

    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // ******************************
    // next state
    // ******************************
    always_comb begin
        next_state = state;
        unique case (state)
            IDLE:       if (player_ready) next_state = GAME_READY;
            GAME_READY: begin
                if (player_unready) next_state = IDLE;      // cancel wins over a late ACK.
                else if (ack_seen)  next_state = IN_GAME;
            end
            IN_GAME: begin
                if (game_end_seen) next_state = IDLE;       // the opponent lost first.
                else if (top_out)  next_state = GAME_LOST;
            end
            GAME_LOST:  if (ack_seen) next_state = IDLE;    // opponent has seen our loss.
        endcase
    end

    assign game_active = (state != IDLE);
    assign in_game     = (state == IN_GAME);
    assign game_lost   = (state == GAME_LOST);

    // ACK goes out while ready, GAME_END while lost, nothing otherwise.
    assign want_send = (state == GAME_READY) || (state == GAME_LOST);

    // a new cycle starts only after the previous one has fully closed.
    assign start_req = want_send && !req && !ack;

    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            req <= 1'b0;
        end else if (start_req) begin
            req <= 1'b1;
        end else if (req && ack) begin
            req <= 1'b0; // frame is out, a state change can act from here on.
        end
    end

    // the packet is latched with req and held until the handshake is over.
    always_ff @(posedge clk) begin
        if (start_req) begin
            pkt.kind    <= (state == GAME_LOST) ? PKT_GAME_END : PKT_ACK;
            pkt.payload <= '0;
        end
    end

endmodule : session_ctrl

// File: hdl/garbage_queue.sv
// ******************************
// outgoing garbage FIFO. holds up to four attack counts
// and sends each as a GARBAGE packet while in game.
// ******************************
`timescale 1ns/100ps

module garbage_queue
    import link_pkg::*;
(
    input  logic      clk,
    input  logic      rst_l,
    input  logic      in_game,     // queue only works during a game.
    input  logic      lines_valid, // game logic has an attack.
    input  garbage_t  lines_count,
    output logic      req,
    input  logic      ack,
    output link_pkt_t pkt
);

    localparam int DEPTH = 4;
    localparam int PTR_W = $clog2(DEPTH);

    garbage_t         fifo_mem [DEPTH]; // counts waiting to be sent.
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [PTR_W:0]   fill;             // number of stored counts.
    logic             full, empty;
    logic             push, pop, start_req;

    assign full  = (fill == (PTR_W+1)'(DEPTH));
    assign empty = (fill == '0);

    // a zero count carries no attack, and a full queue drops the input.
    assign push = in_game && lines_valid && (lines_count != '0) && !full;
    assign pop  = in_game && req && ack; // head has been sent.

    assign start_req = in_game && !empty && !req && !ack;

    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else if (!in_game) begin
            wr_ptr <= '0; // flush, garbage is meaningless outside a game.
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            fill <= fill + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) fifo_mem[wr_ptr] <= lines_count;
        if (start_req) begin
            pkt.kind    <= PKT_GARBAGE;
            pkt.payload <= fifo_mem[rd_ptr]; // head stays put until the pop.
        end
    end

    // a handshake that is already open runs to its end, even after a flush.
    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            req <= 1'b0;
        end else if (start_req) begin
            req <= 1'b1;
        end else if (req && ack) begin
            req <= 1'b0;
        end
    end

endmodule : garbage_queue

// File: hdl/tx_arbiter.sv
// ******************************
// round-robin arbiter that gives the serializer to the
// session FSM or the garbage queue, one handshake at a time.
// ******************************
`timescale 1ns/100ps

module tx_arbiter
    import link_pkg::*;
(
    input  logic      clk,
    input  logic      rst_l,
    input  logic      req_ctrl,
    input  logic      req_garb,
    input  link_pkt_t pkt_ctrl,
    input  link_pkt_t pkt_garb,
    output logic      ack_ctrl,
    output logic      ack_garb,
    output logic      tx_start, // one-cycle pulse to link_tx.
    output link_pkt_t tx_pkt,
    input  logic      tx_done   // stop bit has ended.
);

    typedef enum logic [1:0] {
        ARB_IDLE,    // waiting for a request.
        ARB_SEND,    // frame on the wire.
        ARB_ACK,     // ack high, waiting for req to fall.
        ARB_RELEASE  // ack low again, one guard cycle.
    } arb_state_t;

    arb_state_t state;
    logic       grant_garb;  // owner of the current handshake.
    logic       last_garb;   // owner of the last finished handshake.
    logic       ack_q;
    logic       pick_garb, arb_go, granted_req;

    // on a tie the side that was not served last goes first.
    assign pick_garb   = req_garb && (!req_ctrl || !last_garb);
    assign arb_go      = (state == ARB_IDLE) && (req_ctrl || req_garb);
    assign granted_req = grant_garb ? req_garb : req_ctrl;

    assign ack_ctrl = ack_q && !grant_garb;
    assign ack_garb = ack_q && grant_garb;

    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            state      <= ARB_IDLE;
            grant_garb <= 1'b0;
            last_garb  <= 1'b0;
            ack_q      <= 1'b0;
            tx_start   <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            unique case (state)
                ARB_IDLE: if (arb_go) begin
                    grant_garb <= pick_garb;
                    tx_start   <= 1'b1;
                    state      <= ARB_SEND;
                end
                ARB_SEND: if (tx_done) begin
                    ack_q     <= 1'b1;
                    last_garb <= grant_garb;
                    state     <= ARB_ACK;
                end
                ARB_ACK: if (!granted_req) begin
                    ack_q <= 1'b0; // fourth phase.
                    state <= ARB_RELEASE;
                end
                ARB_RELEASE: state <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (arb_go) tx_pkt <= pick_garb ? pkt_garb : pkt_ctrl;
    end

endmodule : tx_arbiter

// File: hdl/link_tx.sv
// ******************************
// frame serializer. start bit, eight data bits LSB
// first, then the stop bit. line idles high.
// ******************************
`timescale 1ns/100ps

module link_tx
    import link_pkg::*;
#(
    parameter int BIT_CYCLES = 16 // clocks per serial bit.
) (
    input  logic      clk,
    input  logic      rst_l,
    input  logic      start,  // ignored while a frame is going out.
    input  link_pkt_t pkt,
    output logic      done,   // last cycle of the stop bit.
    output logic      tx_line
);

    localparam int CNT_W = $clog2(BIT_CYCLES + 1);

    logic                  busy;
    logic [CNT_W-1:0]      cyc_cnt;  // clocks spent in the current bit.
    bit_idx_t              bit_idx;
    logic [FRAME_BITS-1:0] frame_sr; // bit 0 is on the wire.
    logic                  bit_end;

    assign bit_end = (cyc_cnt == CNT_W'(BIT_CYCLES - 1));
    assign done    = busy && bit_end && (bit_idx == bit_idx_t'(FRAME_BITS - 1));
    assign tx_line = busy ? frame_sr[0] : 1'b1;

    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            busy    <= 1'b0;
            cyc_cnt <= '0;
            bit_idx <= '0;
        end else if (!busy) begin
            if (start) begin
                busy    <= 1'b1;
                cyc_cnt <= '0;
                bit_idx <= '0;
            end
        end else if (bit_end) begin
            cyc_cnt <= '0;
            if (done) busy <= 1'b0;
            else bit_idx <= bit_idx + 1'b1;
        end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && start) frame_sr <= {1'b1, pkt, 1'b0}; // stop, data, start.
        else if (busy && bit_end) frame_sr <= {1'b1, frame_sr[FRAME_BITS-1:1]};
    end

endmodule : link_tx

// File: hdl/link_rx.sv
// ******************************
// frame deserializer. samples each bit mid-period, checks
// the stop bit and turns a good frame into one pulse.
// ******************************
`timescale 1ns/100ps

module link_rx
    import link_pkg::*;
#(
    parameter int BIT_CYCLES = 16
) (
    input  logic     clk,
    input  logic     rst_l,
    input  logic     rx_line,       // already synchronous to clk.
    output logic     ack_seen,
    output logic     game_end_seen,
    output logic     garbage_valid,
    output logic     frame_err,     // stop bit was low.
    output garbage_t garbage_count  // valid with garbage_valid.
);

    localparam int CNT_W = $clog2(BIT_CYCLES + 1);
    localparam int MID   = BIT_CYCLES / 2;

    logic             busy;
    logic             rx_prev;   // line one clock ago, for the start edge.
    logic [CNT_W-1:0] cyc_cnt;
    bit_idx_t         bit_idx;
    logic [7:0]       rx_data;   // data bits shift in from the top.
    link_pkt_t        rx_pkt;
    logic             start_edge, mid_pt, bit_end, stop_bit;

    assign start_edge    = !busy && rx_prev && !rx_line;
    assign mid_pt        = busy && (cyc_cnt == CNT_W'(MID));
    assign bit_end       = (cyc_cnt == CNT_W'(BIT_CYCLES - 1));
    assign stop_bit      = (bit_idx == bit_idx_t'(FRAME_BITS - 1));
    assign rx_pkt        = link_pkt_t'(rx_data);
    assign garbage_count = rx_pkt.payload; // stays until the next frame shifts in.

    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            busy          <= 1'b0;
            rx_prev       <= 1'b1;
            cyc_cnt       <= '0;
            bit_idx       <= '0;
            ack_seen      <= 1'b0;
            game_end_seen <= 1'b0;
            garbage_valid <= 1'b0;
            frame_err     <= 1'b0;
        end else begin
            rx_prev       <= rx_line;
            ack_seen      <= 1'b0;
            game_end_seen <= 1'b0;
            garbage_valid <= 1'b0;
            frame_err     <= 1'b0;
            if (start_edge) begin
                busy    <= 1'b1;
                cyc_cnt <= CNT_W'(1); // the edge cycle is the first of the start bit.
                bit_idx <= '0;
            end else if (busy) begin
                cyc_cnt <= bit_end ? '0 : cyc_cnt + 1'b1;
                if (bit_end) bit_idx <= bit_idx + 1'b1;
                // a start bit that is high again at its middle was a glitch.
                if (mid_pt && (bit_idx == '0) && rx_line) busy <= 1'b0;
                // stop at mid-bit so a frame right behind this one is caught.
                if (mid_pt && stop_bit) begin
                    busy <= 1'b0;
                    if (!rx_line) begin
                        frame_err <= 1'b1;
                    end else begin
                        ack_seen      <= (rx_pkt.kind == PKT_ACK);
                        game_end_seen <= (rx_pkt.kind == PKT_GAME_END);
                        garbage_valid <= (rx_pkt.kind == PKT_GARBAGE);
                    end
                end
            end
        end
    end

    // data bits are 1 to 8, LSB first.
    always_ff @(posedge clk) begin
        if (mid_pt && (bit_idx != '0) && !stop_bit) rx_data <= {rx_line, rx_data[7:1]};
    end

endmodule : link_rx

// File: hdl/link_top.sv
// ******************************
// network link controller for one player. session FSM,
// garbage FIFO, arbiter, serializer and deserializer.
// ******************************
`timescale 1ns/100ps

module link_top
    import link_pkg::*;
#(
    parameter int BIT_CYCLES = 16 // clocks per serial bit on both wires.
) (
    input  logic     clk,
    input  logic     rst_l,
    input  logic     player_ready,
    input  logic     player_unready,
    input  logic     top_out,
    input  logic     lines_valid,
    input  garbage_t lines_count,
    input  logic     rx_line,       // from the opponent.
    output logic     tx_line,       // to the opponent.
    output logic     game_active,
    output logic     in_game,
    output logic     game_lost,
    output logic     garbage_valid, // attack received.
    output garbage_t garbage_count,
    output logic     frame_err
);

    logic      req_ctrl, ack_ctrl, req_garb, ack_garb;
    link_pkt_t pkt_ctrl, pkt_garb, tx_pkt;
    logic      tx_start, tx_done;
    logic      ack_seen, game_end_seen;

    // ******************************
    // packet sources
    // ******************************
    session_ctrl u_session_ctrl (
        .clk, .rst_l, .player_ready, .player_unready, .top_out,
        .ack_seen, .game_end_seen,
        .req (req_ctrl), .ack (ack_ctrl), .pkt (pkt_ctrl),
        .game_active, .in_game, .game_lost
    );

    garbage_queue u_garbage_queue (
        .clk, .rst_l, .in_game, .lines_valid, .lines_count,
        .req (req_garb), .ack (ack_garb), .pkt (pkt_garb)
    );

    // ******************************
    // wire side
    // ******************************
    tx_arbiter u_tx_arbiter (
        .clk, .rst_l, .req_ctrl, .req_garb, .pkt_ctrl, .pkt_garb,
        .ack_ctrl, .ack_garb, .tx_start, .tx_pkt, .tx_done
    );

    link_tx #(.BIT_CYCLES(BIT_CYCLES)) u_link_tx (
        .clk, .rst_l, .start (tx_start), .pkt (tx_pkt), .done (tx_done), .tx_line
    );

    link_rx #(.BIT_CYCLES(BIT_CYCLES)) u_link_rx (
        .clk, .rst_l, .rx_line, .ack_seen, .game_end_seen,
        .garbage_valid, .frame_err, .garbage_count
    );

endmodule : link_top

// File: testbench/link_chk.sv
// ******************************
// handshake and line checks for the link controller,
// bound into link_top.
// ******************************
`timescale 1ns/100ps

module link_chk
    import link_pkg::*;
(
    input logic      clk,
    input logic      rst_l,
    input logic      req_ctrl,
    input logic      ack_ctrl,
    input link_pkt_t pkt_ctrl,
    input logic      req_garb,
    input logic      ack_garb,
    input link_pkt_t pkt_garb,
    input logic      tx_start, // arbiter hands a frame to link_tx.
    input logic      tx_done,  // link_tx ends its stop bit.
    input logic      tx_line
);

    int   fail_cnt = 0; // number of failed assertions so far.
    logic sending;      // a frame runs from start up to done.

    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            sending <= 1'b0;
        end else if (tx_start) begin
            sending <= 1'b1;
        end else if (tx_done) begin
            sending <= 1'b0;
        end
    end

    // ******************************
    // four-phase rules
    // ******************************
    ctrl_hold: assert property (@(posedge clk) disable iff (!rst_l)
        req_ctrl && !ack_ctrl |=> req_ctrl && $stable(pkt_ctrl))
        else begin $error("session req dropped or packet changed before ack"); fail_cnt++; end

    garb_hold: assert property (@(posedge clk) disable iff (!rst_l)
        req_garb && !ack_garb |=> req_garb && $stable(pkt_garb))
        else begin $error("garbage req dropped or packet changed before ack"); fail_cnt++; end

    one_ack: assert property (@(posedge clk) disable iff (!rst_l)
        !(ack_ctrl && ack_garb))
        else begin $error("both sources acknowledged at once"); fail_cnt++; end

    // the wire idles high between frames.
    idle_high: assert property (@(posedge clk) disable iff (!rst_l)
        !sending |-> tx_line)
        else begin $error("tx_line low while the serializer is idle"); fail_cnt++; end

endmodule : link_chk

bind link_top link_chk u_link_chk (
    .clk, .rst_l, .req_ctrl, .ack_ctrl, .pkt_ctrl, .req_garb, .ack_garb, .pkt_garb,
    .tx_start, .tx_done, .tx_line
);

// File: testbench/tb_link_top.sv
// ******************************
// testbench for the link controller. an opponent model
// drives rx_line and decodes tx_line for the checks.
// ******************************
`timescale 1ns/100ps

module tb_link_top
    import link_pkg::*;
();

    localparam int BIT_CYCLES = 4;
    localparam int FRAME_CYC  = FRAME_BITS * BIT_CYCLES; // clocks per frame.
    // frame budget per test: reset, start, send, receive, loss, win, cancel.
    localparam int TEST_FRAMES = 1 + 7 + 13 + 5 + 6 + 8 + 5;
    localparam int TIMEOUT_CYC = TEST_FRAMES * FRAME_CYC + 10 * FRAME_CYC;

    logic     clk, rst_l;
    logic     player_ready, player_unready, top_out, lines_valid, rx_line;
    garbage_t lines_count, garbage_count;
    logic     tx_line, game_active, in_game, game_lost, garbage_valid, frame_err;

    link_pkt_t  mon_q[$];    // packets decoded from tx_line.
    garbage_t   ref_q[$];    // counts expected on tx_line, in order.
    garbage_t   rx_ref_q[$]; // counts expected on garbage_count.
    pkt_kind_t  exp_ctrl_kind = PKT_ACK; // control packet the DUT should send now.
    logic [31:0] seed = 32'h6239f2f8;
    int errors = 0, checks = 0, cycle_cnt = 0;
    int ack_frames = 0, end_frames = 0, garb_frames = 0, frame_errs = 0;

    link_top #(.BIT_CYCLES(BIT_CYCLES)) u_link_top (
        .clk, .rst_l, .player_ready, .player_unready, .top_out, .lines_valid,
        .lines_count, .rx_line, .tx_line, .game_active, .in_game, .game_lost,
        .garbage_valid, .garbage_count, .frame_err
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ******************************
    // helpers and reference model
    // ******************************
    task automatic next_cycle();
        @(posedge clk);
        #0.5; // inputs change just after the edge.
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        assert (got == exp) else begin
            $display("FAILED %s: expected %h, got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_cond(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("check failed: %s", what);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int mark);
        if (errors == mark) $display("test %s: passed", name);
        else $display("test %s: %0d errors", name, errors - mark);
    endtask

    // next LCG step, mapped to a count from 1 to 63.
    function automatic garbage_t next_count();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return garbage_t'((seed[31:16] % 16'd63) + 16'd1);
    endfunction

    // a packet carries its count only when it is an attack.
    function automatic link_pkt_t expected_pkt(input pkt_kind_t kind, input garbage_t count);
        link_pkt_t p;
        p.kind    = kind;
        p.payload = (kind == PKT_GARBAGE) ? count : '0;
        return p;
    endfunction

    // one attack from the game logic, recorded when it should go out.
    task automatic push_lines(input garbage_t count, input logic expect_sent);
        next_cycle();
        lines_valid = 1'b1;
        lines_count = count;
        if (expect_sent) ref_q.push_back(count);
        next_cycle();
        lines_valid = 1'b0;
    endtask

    // opponent side of the wire. start low, data LSB first, chosen stop level.
    task automatic send_frame(input link_pkt_t p, input logic stop);
        logic [FRAME_BITS-1:0] bits;
        bits = {stop, p, 1'b0};
        next_cycle();
        for (int i = 0; i < FRAME_BITS; i++) begin
            rx_line = bits[i];
            repeat (BIT_CYCLES) next_cycle();
        end
        rx_line = 1'b1;
    endtask

    // returns once tx_line has been idle for longer than a frame.
    task automatic wait_quiet();
        int quiet;
        quiet = 0;
        while (quiet < FRAME_CYC + 8) begin
            @(negedge clk);
            quiet = tx_line ? quiet + 1 : 0;
        end
    endtask

    // ******************************
    // opponent monitor and compare
    // ******************************
    initial begin : tx_monitor
        logic [FRAME_BITS-1:0] bits;
        forever begin
            @(negedge clk);
            if (rst_l && !tx_line) begin
                bits[0] = 1'b0;
                for (int i = 1; i < FRAME_BITS; i++) begin
                    repeat (BIT_CYCLES) @(negedge clk); // same spot in each bit.
                    bits[i] = tx_line;
                end
                check_cond(bits[FRAME_BITS-1], "stop bit on tx_line was low");
                mon_q.push_back(link_pkt_t'(bits[8:1]));
            end
        end
    end

    initial begin : tx_compare
        link_pkt_t got;
        forever begin
            @(negedge clk);
            while (mon_q.size() > 0) begin
                got = mon_q.pop_front();
                if (got.kind == PKT_GARBAGE) begin
                    garb_frames++;
                    if (ref_q.size() == 0) check_cond(1'b0, "GARBAGE frame sent with no count queued");
                    else check_value("tx_line packet", expected_pkt(PKT_GARBAGE, ref_q.pop_front()), got);
                end else begin
                    if (got.kind == PKT_ACK) ack_frames++;
                    if (got.kind == PKT_GAME_END) end_frames++;
                    check_value("tx_line packet", expected_pkt(exp_ctrl_kind, '0), got);
                end
            end
        end
    end

    initial begin : rx_compare
        forever begin
            @(negedge clk);
            if (frame_err) frame_errs++;
            if (garbage_valid) begin
                if (rx_ref_q.size() == 0) check_cond(1'b0, "garbage_valid with no GARBAGE frame sent");
                else check_value("garbage_count", rx_ref_q.pop_front(), garbage_count);
            end
        end
    end

    initial begin : watchdog
        while (cycle_cnt < TIMEOUT_CYC) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, a test did not finish", cycle_cnt);
        $display("Finished with errors");
        $finish;
    end

    // ******************************
    // test sequence
    // ******************************
    initial begin : main
        int mark, n;
        rst_l = 1'b0;
        player_ready = 1'b0;
        player_unready = 1'b0;
        top_out = 1'b0;
        lines_valid = 1'b0;
        lines_count = '0;
        rx_line = 1'b1;
        repeat (2) @(posedge clk);
        #0.5 rst_l = 1'b1;

        mark = errors;
        repeat (20) begin
            @(negedge clk);
            check_cond(tx_line && !game_active && !in_game && !game_lost,
                       "outputs left their reset values");
        end
        report_test("reset", mark);

        mark = errors;
        next_cycle();
        player_ready = 1'b1;
        next_cycle();
        player_ready = 1'b0;
        @(negedge clk);
        check_cond(game_active, "game_active did not rise one cycle after player_ready");
        n = 0;
        repeat (3) begin
            @(negedge clk);
            if (!tx_line) n++;
        end
        check_cond(n != 0, "no ACK frame started within three cycles");
        while (ack_frames < 2) @(negedge clk);
        send_frame(expected_pkt(PKT_ACK, '0), 1'b1);
        @(negedge clk);
        check_cond(in_game, "in_game did not rise after the opponent ACK");
        wait_quiet(); // the ACK frame in flight finishes.
        report_test("session start", mark);

        mark = errors;
        n = garb_frames;
        repeat (5) begin
            push_lines(next_count(), 1'b1);
            repeat (2 * FRAME_CYC + 4) next_cycle();
        end
        while (garb_frames < n + 5) @(negedge clk);
        check_value("counts left unsent", 0, ref_q.size());
        report_test("garbage send", mark);

        mark = errors;
        n = frame_errs;
        repeat (3) begin
            rx_ref_q.push_back(next_count());
            send_frame(expected_pkt(PKT_GARBAGE, rx_ref_q[$]), 1'b1);
        end
        send_frame(expected_pkt(PKT_GARBAGE, next_count()), 1'b0); // bad stop bit.
        repeat (4) @(negedge clk);
        check_value("counts not received", 0, rx_ref_q.size());
        check_value("frame_err pulses", n + 1, frame_errs);
        report_test("garbage receive", mark);

        mark = errors;
        n = end_frames;
        exp_ctrl_kind = PKT_GAME_END;
        next_cycle();
        top_out = 1'b1;
        next_cycle();
        top_out = 1'b0;
        @(negedge clk);
        check_cond(game_lost && !in_game, "game_lost did not rise one cycle after top_out");
        while (end_frames < n + 2) @(negedge clk);
        send_frame(expected_pkt(PKT_ACK, '0), 1'b1);
        @(negedge clk);
        check_cond(!game_active, "game_active stayed high after the opponent ACK");
        wait_quiet();
        report_test("loss", mark);

        mark = errors;
        exp_ctrl_kind = PKT_ACK;
        n = ack_frames;
        next_cycle();
        player_ready = 1'b1;
        next_cycle();
        player_ready = 1'b0;
        while (ack_frames == n) @(negedge clk);
        send_frame(expected_pkt(PKT_ACK, '0), 1'b1);
        @(negedge clk);
        check_cond(in_game, "in_game did not rise for the second game");
        wait_quiet();
        n = garb_frames;
        // the head attack is on the wire when the win arrives, the rest is flushed.
        fork
            send_frame(expected_pkt(PKT_GAME_END, '0), 1'b1);
            begin
                repeat (10) next_cycle();
                push_lines(next_count(), 1'b1);
                repeat (3) push_lines(next_count(), 1'b0);
            end
        join
        @(negedge clk);
        check_cond(!in_game && !game_active, "game still active after the opponent GAME_END");
        wait_quiet();
        check_value("garbage frames after the win", n + 1, garb_frames);
        check_value("counts left unsent", 0, ref_q.size());
        report_test("win", mark);

        mark = errors;
        next_cycle();
        player_ready = 1'b1;
        next_cycle();
        player_ready = 1'b0;
        while (tx_line) @(negedge clk); // first ACK frame is out.
        next_cycle();
        player_unready = 1'b1;
        next_cycle();
        player_unready = 1'b0;
        @(negedge clk);
        check_cond(!game_active, "game_active stayed high after player_unready");
        repeat (FRAME_CYC + 8) @(negedge clk); // the frame in flight ends.
        n = 0;
        repeat (3 * FRAME_CYC) begin
            @(negedge clk);
            if (!tx_line) n++;
        end
        check_value("tx_line low cycles after cancel", 0, n);
        report_test("session cancel", mark);

        errors += u_link_top.u_link_chk.fail_cnt;
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
                 u_link_top.u_link_chk.fail_cnt);
        if (errors == 0) $display("Finished with no errors");
        else $display("Finished with errors");
        $finish;
    end

endmodule : tb_link_top

// File: verilog.f
hdl/link_pkg.sv
hdl/session_ctrl.sv
hdl/garbage_queue.sv
hdl/tx_arbiter.sv
hdl/link_tx.sv
hdl/link_rx.sv
hdl/link_top.sv
testbench/link_chk.sv
testbench/tb_link_top.sv

// File: Bender.yml
package:
  name: link_top

sources:
  - hdl/link_pkg.sv
  - hdl/session_ctrl.sv
  - hdl/garbage_queue.sv
  - hdl/tx_arbiter.sv
  - hdl/link_tx.sv
  - hdl/link_rx.sv
  - hdl/link_top.sv
  - target: test
    files:
      - testbench/link_chk.sv
      - testbench/tb_link_top.sv
